// File: src/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Width of addresses and instruction words
`define FETCH_XLEN 32

// First instruction address after reset
`define FETCH_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

// Byte step between sequential instructions
`define FETCH_PC_STEP 32'd4

`endif

// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // RV32 major opcodes handled by the front end
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Immediate layout inside the word
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0, // R-type or unknown
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_kind_e;

    // Branch funct3 codes that are not defined
    localparam logic [2:0] F3_BR_RSVD0 = 3'b010;
    localparam logic [2:0] F3_BR_RSVD1 = 3'b011;

    // Only funct3 value allowed for JALR
    localparam logic [2:0] F3_JALR = 3'b000;

    // Jump classification and static prediction
    typedef struct packed {
        logic taken;  // Redirect fetch to PC + imm
        logic jalr;   // Register indirect, target unknown here
        logic branch; // Conditional branch
    } jump_ctrl_t;

endpackage

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

    // Record handed from fetch to decode
    typedef struct packed {
        logic [`FETCH_XLEN-1:0] instruction;
        logic [`FETCH_XLEN-1:0] imm;
        logic [`FETCH_XLEN-1:0] pc_plus;         // Link value
        logic                   branch_prediction; // 1 when fetch redirected
    } ifid_t;

    // One entry per fetched instruction for the checker
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] instr;
    } trace_t;

    // Flushed IF/ID content, NOP with everything else zero
    localparam ifid_t IFID_FLUSH = '{
        instruction:       `FETCH_NOP,
        imm:               '0,
        pc_plus:           '0,
        branch_prediction: 1'b0
    };

    // Empty trace slot
    localparam trace_t TRACE_IDLE = '{
        valid: 1'b0,
        pc:    '0,
        instr: `FETCH_NOP
    };

endpackage

`default_nettype wire

// File: src/early_imm_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module early_imm_decoder
    import rv_isa_pkg::*;
(
    input  logic [`FETCH_XLEN-1:0] instruction_i,
    output logic [`FETCH_XLEN-1:0] imm_o,
    output imm_kind_e              imm_kind_o
);

    opcode_e   opcode;
    logic      sign;

    assign opcode = opcode_e'(instruction_i[6:0]);
    assign sign   = instruction_i[31];

    // Format from the major opcode
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm_kind_o = IMM_I;
            OPC_STORE:                      imm_kind_o = IMM_S;
            OPC_BRANCH:                     imm_kind_o = IMM_B;
            OPC_LUI, OPC_AUIPC:             imm_kind_o = IMM_U;
            OPC_JAL:                        imm_kind_o = IMM_J;
            default:                        imm_kind_o = IMM_NONE; // OP and unknown
        endcase
    end

    // Bit gathering per format, all sign extended from bit 31
    always_comb begin
        case (imm_kind_o)
            IMM_I: begin
                imm_o = {{(`FETCH_XLEN-12){sign}}, instruction_i[31:20]};
            end
            IMM_S: begin
                imm_o = {{(`FETCH_XLEN-12){sign}}, instruction_i[31:25],
                         instruction_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{(`FETCH_XLEN-13){sign}}, sign, instruction_i[7],
                         instruction_i[30:25], instruction_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {instruction_i[31:12], 12'b0}; // Upper 20 bits, low half zero
            end
            IMM_J: begin
                imm_o = {{(`FETCH_XLEN-21){sign}}, sign, instruction_i[19:12],
                         instruction_i[20], instruction_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/jump_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module jump_controller
    import rv_isa_pkg::*;
(
    input  logic [`FETCH_XLEN-1:0] instruction_i,
    input  imm_kind_e              imm_kind_i,
    input  logic [`FETCH_XLEN-1:0] imm_i,
    output jump_ctrl_t             jump_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_branch;
    logic       backward;

    assign opcode = opcode_e'(instruction_i[6:0]);
    assign funct3 = instruction_i[14:12];

    // Opcode and format must agree, otherwise the word is not a jump
    assign is_jal  = (opcode == OPC_JAL) && (imm_kind_i == IMM_J);
    assign is_jalr = (opcode == OPC_JALR) && (imm_kind_i == IMM_I) && (funct3 == F3_JALR);

    assign is_branch = (opcode == OPC_BRANCH) && (imm_kind_i == IMM_B)
                     && (funct3 != F3_BR_RSVD0) && (funct3 != F3_BR_RSVD1);

    // Negative offset means a loop back edge
    assign backward = imm_i[`FETCH_XLEN-1];

    // Static rule: JAL always, backward branch taken, JALR falls through
    always_comb begin
        jump_o        = '0;
        jump_o.jalr   = is_jalr;
        jump_o.branch = is_branch;
        jump_o.taken  = is_jal || (is_branch && backward);
    end

endmodule

`default_nettype wire

// File: src/pc_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module pc_controller
    import rv_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bubble_i,
    input  logic                   instruction_valid_i,
    input  logic                   misprediction_i,
    input  logic [`FETCH_XLEN-1:0] correct_pc_i,
    input  jump_ctrl_t             jump_i,
    input  logic [`FETCH_XLEN-1:0] imm_i,
    output logic [`FETCH_XLEN-1:0] inst_addr_o,
    output logic [`FETCH_XLEN-1:0] current_pc_o,
    output logic [`FETCH_XLEN-1:0] pc_plus_o
);

    logic [`FETCH_XLEN-1:0] pc_q;
    logic [`FETCH_XLEN-1:0] pc_next;
    logic [`FETCH_XLEN-1:0] jump_target;
    logic                   stall;

    assign pc_plus_o   = pc_q + `FETCH_PC_STEP;
    assign jump_target = pc_q + imm_i; // PC relative target for JAL and branches

    // Memory re-presents the same word while stalled
    assign stall = bubble_i || !instruction_valid_i;

    always_comb begin
        if (misprediction_i) begin
            pc_next = correct_pc_i; // Late correction wins over everything
        end else if (stall) begin
            pc_next = pc_q;
        end else if (jump_i.taken) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc_plus_o;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Address goes straight from the register to instruction memory
    assign inst_addr_o  = pc_q;
    assign current_pc_o = pc_q;

endmodule

`default_nettype wire

// File: src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T           = logic,
    parameter T    CLEAR_VALUE = '0
) (
    input  logic clk,
    input  logic reset,
    input  logic hold_i,
    input  logic clear_i,
    input  T     d_i,
    output T     q_o
);

    T q;

    // One item deep, clear beats hold
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            q <= '0;
        end else if (clear_i) begin
            q <= CLEAR_VALUE;
        end else if (!hold_i) begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_stage
    import rv_isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bubble_i,
    input  logic                   flush_i,
    input  logic                   misprediction_i,
    input  logic                   instruction_valid_i,
    input  logic [`FETCH_XLEN-1:0] correct_pc_i,
    input  logic [`FETCH_XLEN-1:0] instruction_i,
    output logic [`FETCH_XLEN-1:0] inst_addr_o,
    output ifid_t                  ifid_o,
    output trace_t                 trace_o
);

    logic [`FETCH_XLEN-1:0] imm;
    imm_kind_e              imm_kind;
    jump_ctrl_t             jump;
    logic [`FETCH_XLEN-1:0] current_pc;
    logic [`FETCH_XLEN-1:0] pc_plus;

    ifid_t  ifid_d;
    trace_t trace_d;
    logic   ifid_clear;
    logic   trace_clear;

    early_imm_decoder u_imm_dec (
        .instruction_i (instruction_i),
        .imm_o         (imm),
        .imm_kind_o    (imm_kind)
    );

    jump_controller u_jump_ctrl (
        .instruction_i (instruction_i),
        .imm_kind_i    (imm_kind),
        .imm_i         (imm),
        .jump_o        (jump)
    );

    pc_controller u_pc_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .bubble_i            (bubble_i),
        .instruction_valid_i (instruction_valid_i),
        .misprediction_i     (misprediction_i),
        .correct_pc_i        (correct_pc_i),
        .jump_i              (jump),
        .imm_i               (imm),
        .inst_addr_o         (inst_addr_o),
        .current_pc_o        (current_pc),
        .pc_plus_o           (pc_plus)
    );

    // Record contents
    assign ifid_d  = '{instruction: instruction_i, imm: imm, pc_plus: pc_plus,
                       branch_prediction: jump.taken};
    assign trace_d = '{valid: 1'b1, pc: current_pc, instr: instruction_i};

    // A bubble keeps IF/ID even when the memory word is not valid
    assign ifid_clear  = flush_i || (!bubble_i && !instruction_valid_i);
    assign trace_clear = flush_i || bubble_i || !instruction_valid_i;

    pipe_reg #(
        .T           (ifid_t),
        .CLEAR_VALUE (IFID_FLUSH)
    ) u_ifid_reg (
        .clk     (clk),
        .reset   (reset),
        .hold_i  (bubble_i),
        .clear_i (ifid_clear),
        .d_i     (ifid_d),
        .q_o     (ifid_o)
    );

    pipe_reg #(
        .T           (trace_t),
        .CLEAR_VALUE (TRACE_IDLE)
    ) u_trace_reg (
        .clk     (clk),
        .reset   (reset),
        .hold_i  (1'b0),       // Trace reports every cycle
        .clear_i (trace_clear),
        .d_i     (trace_d),
        .q_o     (trace_o)
    );

endmodule

`default_nettype wire

// File: test/fetch_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Active low reset, released on a rising edge
    initial begin
        reset_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/fetch_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_sva
    import fetch_pkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic                   bubble_i,
    input logic                   flush_i,
    input logic                   misprediction_i,
    input logic                   instruction_valid_i,
    input logic [`FETCH_XLEN-1:0] correct_pc_i,
    input logic [`FETCH_XLEN-1:0] inst_addr_o,
    input ifid_t                  ifid_o,
    input trace_t                 trace_o
);

    logic fetch_now;
    logic fetch_seen;

    assign fetch_now = instruction_valid_i && !bubble_i && !flush_i;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fetch_seen <= 1'b0;
        end else if (fetch_now) begin
            fetch_seen <= 1'b1;
        end
    end

    // No trace entry before the first real fetch
    a_trace_quiet: assert property (@(posedge clk) disable iff (!reset)
        (!fetch_seen && !fetch_now) |=> !trace_o.valid)
        else $error("trace valid raised before any fetch");

    a_flush_nop: assert property (@(posedge clk) disable iff (!reset)
        flush_i |=> (ifid_o.instruction == `FETCH_NOP))
        else $error("flush did not load NOP into IF/ID");

    a_mispredict_pc: assert property (@(posedge clk) disable iff (!reset)
        misprediction_i |=> (inst_addr_o == $past(correct_pc_i)))
        else $error("misprediction did not redirect the PC");

    a_bubble_hold: assert property (@(posedge clk) disable iff (!reset)
        (bubble_i && !flush_i && !misprediction_i) |=> ($stable(inst_addr_o) && $stable(ifid_o)))
        else $error("bubble did not hold PC and IF/ID");

endmodule

bind fetch_stage fetch_sva u_fetch_sva (
    .clk                 (clk),
    .reset               (reset),
    .bubble_i            (bubble_i),
    .flush_i             (flush_i),
    .misprediction_i     (misprediction_i),
    .instruction_valid_i (instruction_valid_i),
    .correct_pc_i        (correct_pc_i),
    .inst_addr_o         (inst_addr_o),
    .ifid_o              (ifid_o),
    .trace_o             (trace_o)
);

`default_nettype wire

// File: test/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int NUM_VEC       = 18;
    localparam int WORDS         = 11; // Hex words per golden line
    localparam int RESET_TIMEOUT = 50;

    logic [31:0] golden [0:NUM_VEC*WORDS-1];

    logic                   clk;
    logic                   reset;
    logic                   bubble;
    logic                   flush;
    logic                   misprediction;
    logic                   instruction_valid;
    logic [`FETCH_XLEN-1:0] correct_pc;
    logic [`FETCH_XLEN-1:0] instruction;
    logic [`FETCH_XLEN-1:0] inst_addr;
    ifid_t                  ifid;
    trace_t                 trace;

    int mismatch_count = 0;
    int other_errors   = 0;

    fetch_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    fetch_stage u_fetch_stage (
        .clk                 (clk),
        .reset               (reset),
        .bubble_i            (bubble),
        .flush_i             (flush),
        .misprediction_i     (misprediction),
        .instruction_valid_i (instruction_valid),
        .correct_pc_i        (correct_pc),
        .instruction_i       (instruction),
        .inst_addr_o         (inst_addr),
        .ifid_o              (ifid),
        .trace_o             (trace)
    );

    task automatic check_addr(input logic [`FETCH_XLEN-1:0] got,
                              input logic [`FETCH_XLEN-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: inst_addr_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_ifid(input ifid_t got, input ifid_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: ifid_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_trace(input trace_t got, input trace_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: trace_o got %h expected %h", $time, got, exp);
        end
    endtask

    // Marks a golden word that the file did not overwrite
    function automatic logic [31:0] fill_pattern(input int idx);
        return {16'hBAD0, idx[15:0]};
    endfunction

    // Control nibble is {bubble, flush, misprediction, valid}
    task automatic drive_vector(input int idx);
        int base;
        base = idx * WORDS;
        bubble            <= golden[base][3];
        flush             <= golden[base][2];
        misprediction     <= golden[base][1];
        instruction_valid <= golden[base][0];
        correct_pc        <= golden[base+1];
        instruction       <= golden[base+2];
    endtask

    task automatic compare_vector(input int idx);
        int     base;
        ifid_t  exp_ifid;
        trace_t exp_trace;
        base = idx * WORDS;
        exp_ifid  = '{instruction: golden[base+4], imm: golden[base+5],
                      pc_plus: golden[base+6], branch_prediction: golden[base+7][0]};
        exp_trace = '{valid: golden[base+8][0], pc: golden[base+9], instr: golden[base+10]};
        check_addr(inst_addr, golden[base+3]);
        check_ifid(ifid, exp_ifid);
        check_trace(trace, exp_trace);
    endtask

    initial begin
        int wait_cycles;
        bit golden_ok;

        bubble            = 1'b0;
        flush             = 1'b0;
        misprediction     = 1'b0;
        instruction_valid = 1'b0;
        correct_pc        = '0;
        instruction       = `FETCH_NOP;

        foreach (golden[i]) golden[i] = fill_pattern(i);
        $readmemh("test/fetch_golden.txt", golden);
        golden_ok = 1'b1;
        foreach (golden[i]) begin
            if (golden[i] == fill_pattern(i)) golden_ok = 1'b0;
        end

        if (!golden_ok) begin
            other_errors++;
            $display("Golden file test/fetch_golden.txt is missing or too short");
        end else begin
            // Reset values while reset is still low
            @(negedge clk);
            check_addr(inst_addr, `FETCH_RESET_PC);
            check_ifid(ifid, '0);
            check_trace(trace, '0);

            wait_cycles = 0;
            while (reset !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
                @(posedge clk);
                wait_cycles++;
            end

            if (reset !== 1'b1) begin
                other_errors++;
                $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            end else begin
                for (int i = 0; i < NUM_VEC; i++) begin
                    @(posedge clk);
                    drive_vector(i);
                    @(negedge clk);
                    if (i > 0) compare_vector(i - 1);
                end
                @(posedge clk);
                instruction_valid <= 1'b0; // Idle after the last vector
                @(negedge clk);
                compare_vector(NUM_VEC - 1);
            end
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/rv_isa_pkg.sv
src/fetch_pkg.sv
src/early_imm_decoder.sv
src/jump_controller.sv
src/pc_controller.sv
src/pipe_reg.sv
src/fetch_stage.sv
test/fetch_clock_gen.sv
test/fetch_sva.sv
test/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f src.f \
    --top-module fetch_tb \
    -o fetch_sim

./obj_dir/fetch_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// File: test/fetch_golden.txt
// ctrl{bubble,flush,mispred,valid} correct_pc instr : next inst_addr
// then ifid instr imm pc_plus pred : trace valid pc instr
1 00000000 00500093  00000004 00500093 00000005 00000004 0 1 00000000 00500093
1 00000000 FFF00113  00000008 FFF00113 FFFFFFFF 00000008 0 1 00000004 FFF00113
1 00000000 0020A423  0000000C 0020A423 00000008 0000000C 0 1 00000008 0020A423
1 00000000 123451B7  00000010 123451B7 12345000 00000010 0 1 0000000C 123451B7
1 00000000 010000EF  00000020 010000EF 00000010 00000014 1 1 00000010 010000EF
1 00000000 00009663  00000024 00009663 0000000C 00000024 0 1 00000020 00009663
1 00000000 FE000CE3  0000001C FE000CE3 FFFFFFF8 00000028 1 1 00000024 FE000CE3
1 00000000 00008067  00000020 00008067 00000000 00000020 0 1 0000001C 00008067
// Bubble, then a cycle with no valid word
9 00000000 00500093  00000020 00008067 00000000 00000020 0 0 00000000 00000013
0 00000000 00000000  00000020 00000013 00000000 00000000 0 0 00000000 00000013
1 00000000 00500093  00000024 00500093 00000005 00000024 0 1 00000020 00500093
// Flush and misprediction cases
5 00000000 FFF00113  00000028 00000013 00000000 00000000 0 0 00000000 00000013
3 00000100 010000EF  00000100 010000EF 00000010 0000002C 1 1 00000028 010000EF
B 00000200 00500093  00000200 010000EF 00000010 0000002C 1 0 00000000 00000013
1 00000000 0020A423  00000204 0020A423 00000008 00000204 0 1 00000200 0020A423
7 00000040 FE000CE3  00000040 00000013 00000000 00000000 0 0 00000000 00000013
1 00000000 FFF00113  00000044 FFF00113 FFFFFFFF 00000044 0 1 00000040 FFF00113
1 00000000 FE000CE3  0000003C FE000CE3 FFFFFFF8 00000048 1 1 00000044 FE000CE3
